// ==== source/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module free_list (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     pop,
    input  wire logic                     push,
    input  wire ooo_types_pkg::phys_reg_t push_reg,
    output      ooo_types_pkg::phys_reg_t head_reg,
    output      logic                     empty
);

    // registers beyond the architectural ones start out free
    localparam int DEPTH = `NUM_PHYS_REGS - `NUM_ARCH_REGS;
    localparam int IDX_W = $clog2(DEPTH);

    ooo_types_pkg::phys_reg_t regs [DEPTH];

    logic [IDX_W:0] head_ptr;                            // wrap bit on top
    logic [IDX_W:0] tail_ptr;
    logic           full;

    assign empty = (head_ptr == tail_ptr);
    assign full = (head_ptr[IDX_W-1:0] == tail_ptr[IDX_W-1:0]) &&
                  (head_ptr[IDX_W] != tail_ptr[IDX_W]);
    assign head_reg = regs[head_ptr[IDX_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= (IDX_W + 1)'(DEPTH);             // queue starts full
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= ooo_types_pkg::phys_reg_t'(`NUM_ARCH_REGS + i);
            end
        end else begin
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (push) begin
                regs[tail_ptr[IDX_W-1:0]] <= push_reg;
                tail_ptr <= tail_ptr + 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("free_list: pop while empty");

    // more pushes than pops means a register was freed twice
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("free_list: push while full");

endmodule

`default_nettype wire

// ==== source/ooo_defines.svh ====
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// reorder buffer slots, keep a power of two
`define ROB_DEPTH 16

// physical register file size, fixed by the core
`define NUM_PHYS_REGS 64

// rv32i architectural registers
`define NUM_ARCH_REGS 32

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

// ==== source/ooo_types_pkg.sv ====
`default_nettype none

`include "ooo_defines.svh"

package ooo_types_pkg;

    typedef logic [31:0] word_t;                         // data or pc
    typedef logic [63:0] order_t;                        // instruction sequence number
    typedef logic [4:0]  arch_reg_t;
    typedef logic [5:0]  phys_reg_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // opcodes whose unused source fields read as zero in the monitor
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_imm = 7'b0010011;

    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      regf_we;
        word_t     pc_rdata;
        word_t     pc_wdata;
        order_t    order;
        word_t     inst;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        word_t    rs1_rdata;
        word_t    rs2_rdata;
        word_t    rd_wdata;
    } wb_t;

    // retired instruction record, formal monitor layout
    typedef struct packed {
        logic      valid;
        order_t    order;
        word_t     inst;
        word_t     pc_rdata;
        word_t     pc_wdata;
        arch_reg_t rs1_addr;
        arch_reg_t rs2_addr;
        word_t     rs1_rdata;
        word_t     rs2_rdata;
        arch_reg_t rd_addr;
        word_t     rd_wdata;
        logic      regf_we;
    } monitor_t;

    typedef struct packed {
        logic      valid;
        logic      done;
        phys_reg_t pd;
        phys_reg_t pd_old;                               // mapping replaced by this instruction
        monitor_t  mon;
    } rob_entry_t;

    typedef struct packed {
        monitor_t  mon;
        phys_reg_t pd;
        phys_reg_t pd_old;
    } commit_t;

endpackage

`default_nettype wire

// ==== source/rename_commit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_commit_top (
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire logic                     dispatch_valid,
    input  wire ooo_types_pkg::dispatch_t dispatch,
    output      logic                     dispatch_stall,
    output      ooo_types_pkg::rob_idx_t  dispatch_rob_idx,
    output      ooo_types_pkg::phys_reg_t dispatch_pd,

    input  wire ooo_types_pkg::wb_t       add_wb,
    input  wire ooo_types_pkg::wb_t       mul_wb,
    input  wire ooo_types_pkg::wb_t       div_wb,
    input  wire logic                     mem_done,
    input  wire ooo_types_pkg::rob_idx_t  mem_rob_idx,

    output      logic                     commit_valid,
    output      ooo_types_pkg::commit_t   commit
);

    logic                     need_pd;                   // dispatch writes a real register
    logic                     accept;
    logic                     rob_full;
    logic                     fl_empty;
    logic                     fl_push;
    ooo_types_pkg::phys_reg_t fl_head;
    ooo_types_pkg::phys_reg_t pd_old;

    assign need_pd = dispatch.regf_we && (dispatch.rd != '0);
    assign dispatch_stall = rob_full || (need_pd && fl_empty);
    assign accept = dispatch_valid && !dispatch_stall;
    assign dispatch_pd = need_pd ? fl_head : '0;

    // x0 writers never took a register, so give nothing back
    assign fl_push = commit_valid && commit.mon.regf_we && (commit.mon.rd_addr != '0);

    rob u_rob (
        .clk, .rst,
        .alloc        (accept),
        .alloc_entry  (dispatch),
        .alloc_pd     (dispatch_pd),
        .alloc_pd_old (pd_old),
        .alloc_idx    (dispatch_rob_idx),
        .full         (rob_full),
        .add_wb, .mul_wb, .div_wb,
        .mem_done, .mem_rob_idx,
        .commit_valid, .commit
    );

    free_list u_free_list (
        .clk, .rst,
        .pop      (accept && need_pd),
        .push     (fl_push),
        .push_reg (commit.pd_old),
        .head_reg (fl_head),
        .empty    (fl_empty)
    );

    rename_rat u_rename_rat (
        .clk, .rst,
        .rd     (dispatch.rd),
        .old_pd (pd_old),
        .we     (accept && need_pd),
        .new_pd (fl_head)
    );

    retire_rat u_retire_rat (
        .clk, .rst,
        .we       (commit_valid && commit.mon.regf_we),
        .rd       (commit.mon.rd_addr),
        .pd       (commit.pd),
        .freed_pd (commit.pd_old)
    );

endmodule

`default_nettype wire

// ==== source/rename_rat.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module rename_rat (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire ooo_types_pkg::arch_reg_t rd,
    output      ooo_types_pkg::phys_reg_t old_pd,
    input  wire logic                     we,
    input  wire ooo_types_pkg::phys_reg_t new_pd
);

    // speculative map, runs ahead of retirement
    ooo_types_pkg::phys_reg_t map [`NUM_ARCH_REGS];

    assign old_pd = map[rd];                             // read before this cycle's write

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                map[i] <= ooo_types_pkg::phys_reg_t'(i);    // identity map
            end
        end else if (we && (rd != '0)) begin
            map[rd] <= new_pd;                           // x0 stays on p0
        end
    end

endmodule

`default_nettype wire

// ==== source/retire_rat.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module retire_rat (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     we,
    input  wire ooo_types_pkg::arch_reg_t rd,
    input  wire ooo_types_pkg::phys_reg_t pd,
    input  wire ooo_types_pkg::phys_reg_t freed_pd
);

    // committed map, the state a flush would restore
    ooo_types_pkg::phys_reg_t map [`NUM_ARCH_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                map[i] <= ooo_types_pkg::phys_reg_t'(i);
            end
        end else if (we && (rd != '0)) begin
            map[rd] <= pd;
        end
    end

    // rename at dispatch and commit at retire must agree on the
    // register being released, otherwise a live value gets freed
    a_freed_matches: assert property (
        @(posedge clk) disable iff (rst) we |-> (map[rd] == freed_pd)
    ) else $error("retire_rat: freed p%0d but x%0d maps to p%0d", freed_pd, rd, map[rd]);

endmodule

`default_nettype wire

// ==== source/rob.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module rob #(
    parameter int DEPTH = `ROB_DEPTH
) (
    input  wire logic                     clk,
    input  wire logic                     rst,

    // dispatch side
    input  wire logic                     alloc,
    input  wire ooo_types_pkg::dispatch_t alloc_entry,
    input  wire ooo_types_pkg::phys_reg_t alloc_pd,
    input  wire ooo_types_pkg::phys_reg_t alloc_pd_old,
    output      ooo_types_pkg::rob_idx_t  alloc_idx,
    output      logic                     full,

    // completion side
    input  wire ooo_types_pkg::wb_t       add_wb,
    input  wire ooo_types_pkg::wb_t       mul_wb,
    input  wire ooo_types_pkg::wb_t       div_wb,
    input  wire logic                     mem_done,
    input  wire ooo_types_pkg::rob_idx_t  mem_rob_idx,

    // retire side
    output      logic                     commit_valid,
    output      ooo_types_pkg::commit_t   commit
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int NUM_WB = 3;                           // result buses carrying data
    localparam int NUM_DONE = NUM_WB + 1;                // plus the memory strobe

    ooo_types_pkg::rob_entry_t entries [DEPTH];
    ooo_types_pkg::rob_entry_t head_entry;
    ooo_types_pkg::rob_entry_t new_entry;

    logic [IDX_W:0]   head_ptr;                          // msb is the wrap bit
    logic [IDX_W:0]   tail_ptr;
    logic [IDX_W-1:0] head_slot;
    logic [IDX_W-1:0] tail_slot;
    logic             queue_full;

    ooo_types_pkg::wb_t      wbs [NUM_WB];
    logic                    done_v [NUM_DONE];
    ooo_types_pkg::rob_idx_t done_idx [NUM_DONE];
    logic                    wb_clash;
    logic                    wb_stale;

    assign head_slot = head_ptr[IDX_W-1:0];
    assign tail_slot = tail_ptr[IDX_W-1:0];
    assign alloc_idx = tail_slot;

    assign queue_full = (head_slot == tail_slot) && (head_ptr[IDX_W] != tail_ptr[IDX_W]);
    // a retiring head frees its slot for this cycle's dispatch
    assign full = queue_full && !commit_valid;

    always_comb begin
        head_entry = entries[head_slot];
        commit_valid = head_entry.valid && head_entry.done;
        commit.mon = head_entry.mon;
        commit.mon.valid = commit_valid;
        commit.pd = head_entry.pd;
        commit.pd_old = head_entry.pd_old;
    end

    // monitor fields known at dispatch
    always_comb begin
        new_entry = '0;
        new_entry.valid = 1'b1;
        new_entry.pd = alloc_pd;
        new_entry.pd_old = alloc_pd_old;
        new_entry.mon.order = alloc_entry.order;
        new_entry.mon.inst = alloc_entry.inst;
        new_entry.mon.pc_rdata = alloc_entry.pc_rdata;
        new_entry.mon.pc_wdata = alloc_entry.pc_wdata;
        new_entry.mon.rd_addr = alloc_entry.rd;
        new_entry.mon.regf_we = alloc_entry.regf_we;
        new_entry.mon.rs1_addr = alloc_entry.rs1;
        new_entry.mon.rs2_addr = alloc_entry.rs2;
        if (alloc_entry.inst[6:0] == ooo_types_pkg::op_lui) begin
            new_entry.mon.rs1_addr = '0;
            new_entry.mon.rs2_addr = '0;
        end
        if (alloc_entry.inst[6:0] == ooo_types_pkg::op_imm) begin
            new_entry.mon.rs2_addr = '0;               // immediate takes the rs2 field
        end
    end

    always_comb begin
        wbs[0] = add_wb;
        wbs[1] = mul_wb;
        wbs[2] = div_wb;
        for (int k = 0; k < NUM_WB; k++) begin
            done_v[k] = wbs[k].valid;
            done_idx[k] = wbs[k].rob_idx;
        end
        done_v[NUM_WB] = mem_done;
        done_idx[NUM_WB] = mem_rob_idx;
    end

    // completion sanity, checked below
    always_comb begin
        wb_clash = 1'b0;
        wb_stale = 1'b0;
        for (int i = 0; i < NUM_DONE; i++) begin
            if (done_v[i] && !entries[done_idx[i]].valid) begin
                wb_stale = 1'b1;
            end
            for (int j = i + 1; j < NUM_DONE; j++) begin
                if (done_v[i] && done_v[j] && (done_idx[i] == done_idx[j])) begin
                    wb_clash = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].done <= 1'b0;
            end
        end else begin
            if (commit_valid) begin
                entries[head_slot].valid <= 1'b0;
                head_ptr <= head_ptr + 1'b1;
            end
            for (int k = 0; k < NUM_WB; k++) begin
                if (wbs[k].valid) begin
                    entries[wbs[k].rob_idx].done <= 1'b1;
                    entries[wbs[k].rob_idx].mon.rs1_rdata <= wbs[k].rs1_rdata;
                    entries[wbs[k].rob_idx].mon.rs2_rdata <= wbs[k].rs2_rdata;
                    entries[wbs[k].rob_idx].mon.rd_wdata <=
                        (entries[wbs[k].rob_idx].mon.inst == `NOP_INST) ? '0 : wbs[k].rd_wdata;
                end
            end
            if (mem_done) begin
                entries[mem_rob_idx].done <= 1'b1;    // no data recorded for loads and stores
            end
            if (alloc) begin
                entries[tail_slot] <= new_entry;       // wins over a retire of the same slot
                tail_ptr <= tail_ptr + 1'b1;
            end
        end
    end

    a_alloc_not_full: assert property (@(posedge clk) disable iff (rst) alloc |-> !full)
        else $error("rob: allocation while full");

    a_wb_distinct: assert property (@(posedge clk) disable iff (rst) !wb_clash)
        else $error("rob: two completions to one slot");

    a_wb_live_slot: assert property (@(posedge clk) disable iff (rst) !wb_stale)
        else $error("rob: completion to an empty slot");

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/ooo_types_pkg.sv
source/rob.sv
source/free_list.sv
source/rename_rat.sv
source/retire_rat.sv
source/rename_commit_top.sv
test/rename_commit_tb.sv

// ==== test/rename_commit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module rename_commit_tb;

    localparam int DEPTH = `ROB_DEPTH;
    localparam int TIMEOUT_CYCLES = 4000;                // bound on the whole run
    localparam logic [31:0] PC_BASE = 32'h0000_1000;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_REG = 7'b0110011;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     dispatch_valid;
    ooo_types_pkg::dispatch_t dispatch;
    logic                     dispatch_stall;
    ooo_types_pkg::rob_idx_t  dispatch_rob_idx;
    ooo_types_pkg::phys_reg_t dispatch_pd;
    ooo_types_pkg::wb_t       wb_bus [3];                // add, mul, div
    logic                     mem_done;
    ooo_types_pkg::rob_idx_t  mem_rob_idx;
    logic                     commit_valid;
    ooo_types_pkg::commit_t   commit;

    // reference model with one row per dispatched instruction
    ooo_types_pkg::monitor_t  exp_tab [256];
    ooo_types_pkg::phys_reg_t exp_pd [256];
    ooo_types_pkg::phys_reg_t exp_pd_old [256];
    logic                     exp_done [256];
    logic [31:0]              slot_order [DEPTH];        // which order sits in each slot
    ooo_types_pkg::phys_reg_t ref_map [32];              // speculative map as the model sees it
    logic                     in_use [64];
    logic [31:0]              disp_cnt = '0;
    logic [31:0]              ret_cnt = '0;

    ooo_types_pkg::monitor_t  exp_mon;
    logic [11:0]              exp_pds;
    logic                     exp_commit;
    logic                     exp_stall;
    logic                     accept_exp;
    logic                     need_pd_exp;

    integer seed;
    int     errors = 0;
    int     mark = 0;
    int     tests = 0;
    int     cycles = 0;

    always #50 clk = ~clk;

    rename_commit_top dut (
        .clk, .rst,
        .dispatch_valid, .dispatch, .dispatch_stall, .dispatch_rob_idx, .dispatch_pd,
        .add_wb (wb_bus[0]),
        .mul_wb (wb_bus[1]),
        .div_wb (wb_bus[2]),
        .mem_done, .mem_rob_idx,
        .commit_valid, .commit
    );

    always_comb begin
        exp_mon = exp_tab[ret_cnt[7:0]];
        exp_pds = {exp_pd[ret_cnt[7:0]], exp_pd_old[ret_cnt[7:0]]};
    end

    assign exp_commit = (disp_cnt != ret_cnt) && exp_done[ret_cnt[7:0]];
    assign exp_stall = ((disp_cnt - ret_cnt) == DEPTH) && !exp_commit;    // free list never runs dry here
    assign accept_exp = dispatch_valid && !exp_stall;
    assign need_pd_exp = dispatch.regf_we && (dispatch.rd != '0);

    always @(posedge clk) begin
        logic       do_commit;
        logic       do_accept;
        logic [7:0] ret;
        logic [7:0] disp;
        if (rst) begin
            disp_cnt = '0;
            ret_cnt = '0;
            for (int i = 0; i < 32; i++) begin
                ref_map[i] = ooo_types_pkg::phys_reg_t'(i);
            end
            for (int i = 0; i < 64; i++) begin
                in_use[i] = (i < 32);
            end
        end else begin
            do_commit = exp_commit;                      // state before this edge
            do_accept = accept_exp;
            ret = ret_cnt[7:0];
            disp = disp_cnt[7:0];
            for (int k = 0; k < 3; k++) begin
                if (wb_bus[k].valid) begin
                    exp_done[slot_order[wb_bus[k].rob_idx][7:0]] = 1'b1;
                end
            end
            if (mem_done) begin
                exp_done[slot_order[mem_rob_idx][7:0]] = 1'b1;
            end
            if (do_commit) begin
                if (exp_tab[ret].regf_we && (exp_tab[ret].rd_addr != '0)) begin
                    in_use[exp_pd_old[ret]] = 1'b0;
                end
                ret_cnt = ret_cnt + 1;
            end
            if (do_accept) begin
                exp_pd[disp] = dispatch_pd;
                exp_pd_old[disp] = ref_map[dispatch.rd];
                if (need_pd_exp) begin
                    ref_map[dispatch.rd] = dispatch_pd;
                    in_use[dispatch_pd] = 1'b1;
                end
                slot_order[disp_cnt % DEPTH] = disp_cnt;
                disp_cnt = disp_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles, %0d of %0d retired",
                cycles, ret_cnt, disp_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic flag_mismatch(input string name, input logic [511:0] got,
                                 input logic [511:0] expd);
        errors++;
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, expd);
    endtask

    task automatic flag_failure(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    a_commit_valid: assert property (@(posedge clk) disable iff (rst)
        commit_valid == exp_commit)
        else flag_mismatch("commit_valid", $sampled(commit_valid), $sampled(exp_commit));

    // order, pc, inst, addresses and data in one compare
    a_record: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit.mon == exp_mon)
        else flag_mismatch("commit.mon", $sampled(commit.mon), $sampled(exp_mon));

    a_pds: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> {commit.pd, commit.pd_old} == exp_pds)
        else flag_mismatch("{commit.pd, commit.pd_old}",
            $sampled({commit.pd, commit.pd_old}), $sampled(exp_pds));

    a_stall: assert property (@(posedge clk) disable iff (rst)
        dispatch_stall == exp_stall)
        else flag_mismatch("dispatch_stall", $sampled(dispatch_stall), $sampled(exp_stall));

    a_rob_idx: assert property (@(posedge clk) disable iff (rst)
        accept_exp |-> dispatch_rob_idx == ooo_types_pkg::rob_idx_t'(disp_cnt))
        else flag_mismatch("dispatch_rob_idx", $sampled(dispatch_rob_idx),
            $sampled(disp_cnt % DEPTH));

    a_pd_free: assert property (@(posedge clk) disable iff (rst)
        accept_exp && need_pd_exp |-> !in_use[dispatch_pd])
        else flag_failure($sformatf("dispatch_pd p%0d handed out while still in use",
            $sampled(dispatch_pd)));

    a_pd_zero: assert property (@(posedge clk) disable iff (rst)
        accept_exp && !need_pd_exp |-> dispatch_pd == '0)
        else flag_mismatch("dispatch_pd", $sampled(dispatch_pd), 0);

    // kind 0 nop, 1 lui, 2 addi, 3 add
    task automatic issue_dispatch(input int kind, input ooo_types_pkg::arch_reg_t rd,
                                  input ooo_types_pkg::arch_reg_t rs1,
                                  input ooo_types_pkg::arch_reg_t rs2);
        ooo_types_pkg::monitor_t m;
        logic [31:0]             start;
        start = disp_cnt;
        case (kind)
            0:       dispatch.inst = `NOP_INST;
            1:       dispatch.inst = {20'h12345, rd, OP_LUI};
            2:       dispatch.inst = {12'h07f, rs1, 3'b000, rd, OP_IMM};
            default: dispatch.inst = {7'h00, rs2, rs1, 3'b000, rd, OP_REG};
        endcase
        dispatch.rd = rd;
        dispatch.rs1 = rs1;
        dispatch.rs2 = rs2;
        dispatch.regf_we = 1'b1;
        dispatch.pc_rdata = PC_BASE + (start << 2);
        dispatch.pc_wdata = PC_BASE + (start << 2) + 4;
        dispatch.order = 64'(start);
        m = '0;
        m.valid = 1'b1;
        m.order = 64'(start);
        m.inst = dispatch.inst;
        m.pc_rdata = dispatch.pc_rdata;
        m.pc_wdata = dispatch.pc_wdata;
        m.rd_addr = rd;
        m.regf_we = 1'b1;
        m.rs1_addr = (dispatch.inst[6:0] == OP_LUI) ? '0 : rs1;
        m.rs2_addr = (dispatch.inst[6:0] inside {OP_LUI, OP_IMM}) ? '0 : rs2;
        exp_tab[start[7:0]] = m;
        exp_done[start[7:0]] = 1'b0;
        dispatch_valid = 1'b1;
        while (disp_cnt == start) begin                  // held through a stall
            @(negedge clk);
        end
        dispatch_valid = 1'b0;
    endtask

    // src 3 is the memory strobe and carries no data
    task automatic drive_done(input int src, input logic [31:0] ord);
        ooo_types_pkg::wb_t wb;
        if (src == 3) begin
            mem_done = 1'b1;
            mem_rob_idx = ooo_types_pkg::rob_idx_t'(ord);
        end else begin
            wb.valid = 1'b1;
            wb.rob_idx = ooo_types_pkg::rob_idx_t'(ord);
            wb.rs1_rdata = $random(seed);
            wb.rs2_rdata = $random(seed);
            wb.rd_wdata = $random(seed);
            wb_bus[src] = wb;
            exp_tab[ord[7:0]].rs1_rdata = wb.rs1_rdata;
            exp_tab[ord[7:0]].rs2_rdata = wb.rs2_rdata;
            exp_tab[ord[7:0]].rd_wdata =
                (exp_tab[ord[7:0]].inst == `NOP_INST) ? '0 : wb.rd_wdata;
        end
    endtask

    task automatic clear_done();
        for (int k = 0; k < 3; k++) begin
            wb_bus[k] = '0;
        end
        mem_done = 1'b0;
    endtask

    // completes orders first..first+n-1 in random order with up to four per cycle
    task automatic complete_orders(input int first, input int n);
        int pend[$];
        int src;
        int count;
        int j;
        for (int i = 0; i < n; i++) begin
            pend.push_back(first + i);
        end
        while (pend.size() > 0) begin
            src = $unsigned($random(seed)) % 4;
            count = 1 + $unsigned($random(seed)) % 4;
            for (int k = 0; (k < count) && (pend.size() > 0); k++) begin
                j = $unsigned($random(seed)) % pend.size();
                drive_done((src + k) % 4, pend[j]);      // distinct sources, distinct slots
                pend.delete(j);
            end
            @(negedge clk);
            clear_done();
        end
    endtask

    task automatic end_test(input string name);
        while (ret_cnt != disp_cnt) begin
            @(negedge clk);
        end
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - mark);
        mark = errors;
    endtask

    initial begin
        int base;
        int kind;
        seed = 32'hc1f6_a928;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch = '0;
        mem_rob_idx = '0;
        clear_done();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        base = disp_cnt;
        for (int i = 0; i < 16; i++) begin
            kind = $unsigned($random(seed)) % 4;
            if (kind == 0) begin
                issue_dispatch(0, 0, 0, 0);
            end else begin
                issue_dispatch(kind,
                    ooo_types_pkg::arch_reg_t'(1 + $unsigned($random(seed)) % 31),
                    ooo_types_pkg::arch_reg_t'($random(seed)),
                    ooo_types_pkg::arch_reg_t'($random(seed)));
            end
        end
        complete_orders(base, 16);
        end_test("in-order retire");

        base = disp_cnt;
        for (int i = 0; i < DEPTH; i++) begin
            issue_dispatch(3, 10 + i % 8, 1, 2);
        end
        fork
            issue_dispatch(3, 20, 3, 4);                 // stalls until the head retires
            begin
                repeat (4) @(negedge clk);
                drive_done(1, base);
                @(negedge clk);
                clear_done();
            end
        join
        complete_orders(base + 1, DEPTH);
        end_test("full stall");

        base = disp_cnt;
        issue_dispatch(0, 0, 0, 0);
        issue_dispatch(1, 7, 9, 10);                     // lui with stray source fields
        issue_dispatch(2, 8, 3, 11);
        issue_dispatch(3, 9, 7, 8);
        drive_done(0, base);                             // nop result must read as zero
        @(negedge clk);
        clear_done();
        complete_orders(base + 1, 3);
        end_test("monitor rules");

        base = disp_cnt;
        for (int i = 0; i < 12; i++) begin
            issue_dispatch(3, 5 + i % 2, 5 + i % 2, 6);
        end
        complete_orders(base, 12);
        end_test("register recycling");

        base = disp_cnt;
        issue_dispatch(3, 0, 1, 2);
        issue_dispatch(2, 4, 0, 0);
        issue_dispatch(3, 0, 4, 4);
        issue_dispatch(1, 0, 0, 0);
        complete_orders(base, 4);
        // enough writers to cycle the whole free list past the x0 commits
        for (int r = 0; r < 3; r++) begin
            base = disp_cnt;
            for (int i = 0; i < 12; i++) begin
                issue_dispatch(2, ooo_types_pkg::arch_reg_t'(1 + i), 0, 0);
            end
            complete_orders(base, 12);
        end
        end_test("register zero");

        $display("%0d tests, %0d commits, %0d errors", tests, ret_cnt, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
